/* mips_id_pkg.sv */
package mips_id_pkg;

    // widths fixed by the instruction set
    localparam int reg_addr_w = 5;
    localparam int word_w     = 32;
    localparam int alu_op_w   = 12;

    // primary opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_regimm  = 6'h01;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_blez    = 6'h06;
    localparam logic [5:0] op_bgtz    = 6'h07;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // special function codes
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_sllv = 6'h04;
    localparam logic [5:0] fn_srlv = 6'h06;
    localparam logic [5:0] fn_srav = 6'h07;
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_jalr = 6'h09;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    // regimm selectors in the rt field
    localparam logic [4:0] rt_bltz = 5'h00;
    localparam logic [4:0] rt_bgez = 5'h01;

    // stall codes from the hazard unit
    localparam logic [1:0] stall_run    = 2'b00;
    localparam logic [1:0] stall_hold   = 2'b01;
    localparam logic [1:0] stall_bubble = 2'b10;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] sa;
        logic [5:0] func;
    } inst_r_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } inst_i_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] index;
    } inst_j_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_j_t j;
    } inst_u;

    typedef struct packed {
        inst_u              inst;
        logic [word_w-1:0]  pc;
    } fs_to_ds_t;

    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] waddr;
        logic [word_w-1:0]     wdata;
    } rf_write_t;

    typedef struct packed {
        logic use_fwd_rs;
        logic use_fwd_rt;
    } fwd_t;

    typedef struct packed {
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
    } src_addr_t;

    typedef struct packed {
        logic [alu_op_w-1:0]   alu_op;
        logic                  src1_is_sa;
        logic                  src1_is_pc;
        logic                  src2_is_simm;
        logic                  src2_is_uimm;
        logic                  src2_is_8;
        logic                  res_from_mem;
        logic                  gr_we;
        logic                  mem_we;
        logic [reg_addr_w-1:0] dest;
    } dec_ctrl_t;

    typedef struct packed {
        dec_ctrl_t         ctrl;
        logic [15:0]       imm;
        logic [word_w-1:0] rs_value;
        logic [word_w-1:0] rt_value;
        logic [word_w-1:0] pc;
    } ds_to_es_t;

    typedef struct packed {
        logic              taken;
        logic [word_w-1:0] target;
    } br_bus_t;

endpackage

/* id_pipe_ctrl.sv */
`timescale 1ns/100ps

module id_pipe_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   es_allowin,
    input  logic                   fs_to_ds_valid,
    input  logic [1:0]             stall,
    input  mips_id_pkg::fs_to_ds_t fs_to_ds,
    output logic                   ds_allowin,
    output logic                   ds_valid,
    output logic                   ds_to_es_valid,
    output mips_id_pkg::fs_to_ds_t ds_inst_pc
);

    // stall override on both handshake levels
    always_comb begin
        case (stall)
            mips_id_pkg::stall_hold: begin
                ds_allowin     = 1'b0;
                ds_to_es_valid = 1'b0;
            end
            mips_id_pkg::stall_bubble: begin
                ds_allowin     = 1'b1;
                ds_to_es_valid = 1'b0;
            end
            default: begin
                ds_allowin     = !ds_valid || es_allowin;
                ds_to_es_valid = ds_valid;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    // instruction register, loaded only on a fetch transfer
    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_inst_pc <= fs_to_ds;
        end
    end

    // a held or back-pressured instruction stays put across the edge
    held_inst_stable: assert property (@(posedge clk) disable iff (rst)
        (ds_valid && !ds_allowin && !flush) |=> ds_valid && $stable(ds_inst_pc));

endmodule

/* inst_decoder.sv */
`timescale 1ns/100ps

module inst_decoder (
    input  mips_id_pkg::inst_u     inst,
    output mips_id_pkg::dec_ctrl_t ctrl,
    output logic                   is_branch,
    output logic                   is_jump_reg,
    output logic                   is_jump_imm
);

    logic is_special, is_regimm;
    logic rs_zero, rt_zero, rd_zero, sa_zero;
    logic inst_addu, inst_subu, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_xor, inst_nor;
    logic inst_sll, inst_srl, inst_sra, inst_sllv, inst_srlv, inst_srav;
    logic inst_addiu, inst_slti, inst_sltiu, inst_andi, inst_ori, inst_xori, inst_lui;
    logic inst_lw, inst_sw;
    logic inst_beq, inst_bne, inst_bgez, inst_bgtz, inst_blez, inst_bltz;
    logic inst_j, inst_jal, inst_jr, inst_jalr;
    logic alu_reg, alu_imm;

    assign is_special = inst.r.op == mips_id_pkg::op_special;
    assign is_regimm  = inst.r.op == mips_id_pkg::op_regimm;
    assign rs_zero    = inst.r.rs == '0;
    assign rt_zero    = inst.r.rt == '0;
    assign rd_zero    = inst.r.rd == '0;
    assign sa_zero    = inst.r.sa == '0;

    // register-register ALU ops need a zero shift amount
    assign inst_addu = is_special && sa_zero && inst.r.func == mips_id_pkg::fn_addu;
    assign inst_subu = is_special && sa_zero && inst.r.func == mips_id_pkg::fn_subu;
    assign inst_slt  = is_special && sa_zero && inst.r.func == mips_id_pkg::fn_slt;
    assign inst_sltu = is_special && sa_zero && inst.r.func == mips_id_pkg::fn_sltu;
    assign inst_and  = is_special && sa_zero && inst.r.func == mips_id_pkg::fn_and;
    assign inst_or   = is_special && sa_zero && inst.r.func == mips_id_pkg::fn_or;
    assign inst_xor  = is_special && sa_zero && inst.r.func == mips_id_pkg::fn_xor;
    assign inst_nor  = is_special && sa_zero && inst.r.func == mips_id_pkg::fn_nor;
    assign inst_sllv = is_special && sa_zero && inst.r.func == mips_id_pkg::fn_sllv;
    assign inst_srlv = is_special && sa_zero && inst.r.func == mips_id_pkg::fn_srlv;
    assign inst_srav = is_special && sa_zero && inst.r.func == mips_id_pkg::fn_srav;

    // constant shifts leave rs unused
    assign inst_sll = is_special && rs_zero && inst.r.func == mips_id_pkg::fn_sll;
    assign inst_srl = is_special && rs_zero && inst.r.func == mips_id_pkg::fn_srl;
    assign inst_sra = is_special && rs_zero && inst.r.func == mips_id_pkg::fn_sra;

    assign inst_addiu = inst.i.op == mips_id_pkg::op_addiu;
    assign inst_slti  = inst.i.op == mips_id_pkg::op_slti;
    assign inst_sltiu = inst.i.op == mips_id_pkg::op_sltiu;
    assign inst_andi  = inst.i.op == mips_id_pkg::op_andi;
    assign inst_ori   = inst.i.op == mips_id_pkg::op_ori;
    assign inst_xori  = inst.i.op == mips_id_pkg::op_xori;
    assign inst_lui   = inst.i.op == mips_id_pkg::op_lui && rs_zero;
    assign inst_lw    = inst.i.op == mips_id_pkg::op_lw;
    assign inst_sw    = inst.i.op == mips_id_pkg::op_sw;

    assign inst_beq  = inst.i.op == mips_id_pkg::op_beq;
    assign inst_bne  = inst.i.op == mips_id_pkg::op_bne;
    assign inst_bgtz = inst.i.op == mips_id_pkg::op_bgtz && rt_zero;
    assign inst_blez = inst.i.op == mips_id_pkg::op_blez && rt_zero;
    assign inst_bgez = is_regimm && inst.i.rt == mips_id_pkg::rt_bgez;
    assign inst_bltz = is_regimm && inst.i.rt == mips_id_pkg::rt_bltz;
    assign inst_j    = inst.j.op == mips_id_pkg::op_j;
    assign inst_jal  = inst.j.op == mips_id_pkg::op_jal;
    assign inst_jr   = is_special && rt_zero && rd_zero && sa_zero
                       && inst.r.func == mips_id_pkg::fn_jr;
    assign inst_jalr = is_special && rt_zero && sa_zero && inst.r.func == mips_id_pkg::fn_jalr;

    assign alu_reg = inst_addu | inst_subu | inst_slt | inst_sltu | inst_and | inst_or
                   | inst_xor | inst_nor | inst_sll | inst_srl | inst_sra
                   | inst_sllv | inst_srlv | inst_srav;
    assign alu_imm = inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori | inst_xori;

    // one-hot ALU operation, bit 0 is addition
    assign ctrl.alu_op[0]  = inst_addu | inst_addiu | inst_lw | inst_sw | inst_jal | inst_jalr;
    assign ctrl.alu_op[1]  = inst_subu;
    assign ctrl.alu_op[2]  = inst_slt | inst_slti;
    assign ctrl.alu_op[3]  = inst_sltu | inst_sltiu;
    assign ctrl.alu_op[4]  = inst_and | inst_andi;
    assign ctrl.alu_op[5]  = inst_nor;
    assign ctrl.alu_op[6]  = inst_or | inst_ori;
    assign ctrl.alu_op[7]  = inst_xor | inst_xori;
    assign ctrl.alu_op[8]  = inst_sll | inst_sllv;
    assign ctrl.alu_op[9]  = inst_srl | inst_srlv;
    assign ctrl.alu_op[10] = inst_sra | inst_srav;
    assign ctrl.alu_op[11] = inst_lui;

    assign ctrl.src1_is_sa   = inst_sll | inst_srl | inst_sra;
    assign ctrl.src1_is_pc   = inst_jal | inst_jalr;
    assign ctrl.src2_is_simm = inst_addiu | inst_slti | inst_sltiu | inst_lui | inst_lw | inst_sw;
    assign ctrl.src2_is_uimm = inst_andi | inst_ori | inst_xori;
    // link value is pc+8
    assign ctrl.src2_is_8    = inst_jal | inst_jalr;
    assign ctrl.res_from_mem = inst_lw;
    assign ctrl.mem_we       = inst_sw;
    // unknown words fall through with no write enable
    assign ctrl.gr_we        = alu_reg | alu_imm | inst_lui | inst_lw | inst_jal | inst_jalr;

    assign ctrl.dest = inst_jal                       ? 5'd31 :
                       (alu_imm | inst_lui | inst_lw) ? inst.i.rt :
                                                        inst.r.rd;

    assign is_branch   = inst_beq | inst_bne | inst_bgez | inst_bgtz | inst_blez | inst_bltz;
    assign is_jump_reg = inst_jr | inst_jalr;
    assign is_jump_imm = inst_j | inst_jal;

    alu_op_onehot: assert final ($onehot0(ctrl.alu_op));

endmodule

/* reg_file.sv */
`timescale 1ns/100ps

module reg_file (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [mips_id_pkg::reg_addr_w-1:0]  raddr1,
    input  logic [mips_id_pkg::reg_addr_w-1:0]  raddr2,
    input  mips_id_pkg::rf_write_t              wr,
    output logic [mips_id_pkg::word_w-1:0]      rdata1,
    output logic [mips_id_pkg::word_w-1:0]      rdata2
);

    logic [mips_id_pkg::word_w-1:0] regs [32];

    // register 0 is never written, so it stays at its reset value
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we && wr.waddr != '0) begin
            regs[wr.waddr] <= wr.wdata;
        end
    end

    // no bypass, a same-cycle write shows up after the edge
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    zero_reads_zero: assert property (@(posedge clk) disable iff (rst)
        (raddr1 == '0 |-> rdata1 == '0) and (raddr2 == '0 |-> rdata2 == '0));

endmodule

/* operand_fwd.sv */
`timescale 1ns/100ps

module operand_fwd (
    input  logic                           clk,
    input  logic                           rst,
    input  mips_id_pkg::src_addr_t         src,
    input  mips_id_pkg::rf_write_t         wr,
    input  mips_id_pkg::fwd_t              fwd,
    input  logic [mips_id_pkg::word_w-1:0] fwd_data,
    output logic [mips_id_pkg::word_w-1:0] rs_value,
    output logic [mips_id_pkg::word_w-1:0] rt_value
);

    logic [mips_id_pkg::word_w-1:0] rf_rdata1;
    logic [mips_id_pkg::word_w-1:0] rf_rdata2;

    reg_file reg_file_inst (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (src.rs),
        .raddr2 (src.rt),
        .wr     (wr),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    // hazard unit picks the forwarded value over the file
    assign rs_value = fwd.use_fwd_rs ? fwd_data : rf_rdata1;
    assign rt_value = fwd.use_fwd_rt ? fwd_data : rf_rdata2;

endmodule

/* branch_unit.sv */
`timescale 1ns/100ps

module branch_unit (
    input  logic                           ds_valid,
    input  mips_id_pkg::inst_u             inst,
    input  logic [mips_id_pkg::word_w-1:0] pc,
    input  logic [mips_id_pkg::word_w-1:0] rs_value,
    input  logic [mips_id_pkg::word_w-1:0] rt_value,
    input  logic                           is_branch,
    input  logic                           is_jump_reg,
    input  logic                           is_jump_imm,
    output mips_id_pkg::br_bus_t           br
);

    logic [mips_id_pkg::word_w-1:0] pc_plus4;
    logic [mips_id_pkg::word_w-1:0] branch_target;
    logic [mips_id_pkg::word_w-1:0] jump_target;
    logic                           rs_eq_rt;
    logic                           rs_eq_0;
    logic                           rs_lt_0;
    logic                           cond;

    // delay slot address
    assign pc_plus4 = pc + 32'd4;

    assign rs_eq_rt = rs_value == rt_value;
    assign rs_eq_0  = rs_value == '0;
    assign rs_lt_0  = rs_value[31];

    // is_branch already checks the rt field of the regimm and blez/bgtz forms
    always_comb begin
        case (inst.i.op)
            mips_id_pkg::op_beq:    cond = rs_eq_rt;
            mips_id_pkg::op_bne:    cond = !rs_eq_rt;
            mips_id_pkg::op_bgtz:   cond = !rs_lt_0 && !rs_eq_0;
            mips_id_pkg::op_blez:   cond = rs_lt_0 || rs_eq_0;
            mips_id_pkg::op_regimm: cond = (inst.i.rt == mips_id_pkg::rt_bgez) ? !rs_lt_0 : rs_lt_0;
            default:                cond = 1'b0;
        endcase
    end

    assign branch_target = pc_plus4 + {{14{inst.i.imm[15]}}, inst.i.imm, 2'b00};
    assign jump_target   = {pc_plus4[31:28], inst.j.index, 2'b00};

    assign br.taken  = ds_valid && ((is_branch && cond) || is_jump_reg || is_jump_imm);
    assign br.target = is_branch   ? branch_target :
                       is_jump_reg ? rs_value :
                                     jump_target;

endmodule

/* id_stage.sv */
`timescale 1ns/100ps

module id_stage (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           fs_to_ds_valid,
    input  mips_id_pkg::fs_to_ds_t         fs_to_ds,
    output logic                           ds_allowin,
    input  logic                           es_allowin,
    output logic                           ds_to_es_valid,
    output mips_id_pkg::ds_to_es_t         ds_to_es,
    input  mips_id_pkg::rf_write_t         ws_to_rf,
    input  logic [mips_id_pkg::word_w-1:0] fwd_data,
    input  mips_id_pkg::fwd_t              fwd,
    input  logic [1:0]                     stall,
    input  logic                           flush,
    output mips_id_pkg::br_bus_t           br,
    output mips_id_pkg::src_addr_t         src_addrs,
    output logic                           is_branch
);

    logic                           ds_valid;
    mips_id_pkg::fs_to_ds_t         ds_inst_pc;
    mips_id_pkg::dec_ctrl_t         ctrl;
    logic                           is_jump_reg;
    logic                           is_jump_imm;
    logic [mips_id_pkg::word_w-1:0] rs_value;
    logic [mips_id_pkg::word_w-1:0] rt_value;

    id_pipe_ctrl id_pipe_ctrl_inst (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .es_allowin     (es_allowin),
        .fs_to_ds_valid (fs_to_ds_valid),
        .stall          (stall),
        .fs_to_ds       (fs_to_ds),
        .ds_allowin     (ds_allowin),
        .ds_valid       (ds_valid),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_inst_pc     (ds_inst_pc)
    );

    inst_decoder inst_decoder_inst (
        .inst        (ds_inst_pc.inst),
        .ctrl        (ctrl),
        .is_branch   (is_branch),
        .is_jump_reg (is_jump_reg),
        .is_jump_imm (is_jump_imm)
    );

    // source indices also go back to the hazard unit
    assign src_addrs.rs = ds_inst_pc.inst.r.rs;
    assign src_addrs.rt = ds_inst_pc.inst.r.rt;

    operand_fwd operand_fwd_inst (
        .clk      (clk),
        .rst      (rst),
        .src      (src_addrs),
        .wr       (ws_to_rf),
        .fwd      (fwd),
        .fwd_data (fwd_data),
        .rs_value (rs_value),
        .rt_value (rt_value)
    );

    branch_unit branch_unit_inst (
        .ds_valid    (ds_valid),
        .inst        (ds_inst_pc.inst),
        .pc          (ds_inst_pc.pc),
        .rs_value    (rs_value),
        .rt_value    (rt_value),
        .is_branch   (is_branch),
        .is_jump_reg (is_jump_reg),
        .is_jump_imm (is_jump_imm),
        .br          (br)
    );

    assign ds_to_es.ctrl     = ctrl;
    assign ds_to_es.imm      = ds_inst_pc.inst.i.imm;
    assign ds_to_es.rs_value = rs_value;
    assign ds_to_es.rt_value = rt_value;
    assign ds_to_es.pc       = ds_inst_pc.pc;

endmodule

/* id_checker.sv */
`timescale 1ns/100ps

module id_checker (
    input  logic                           clk,
    input  logic                           rst,
    input  int                             req_id,
    input  logic [127:0]                   name,
    input  logic                           e_valid,
    input  logic [11:0]                    e_alu_op,
    input  logic [4:0]                     e_dest,
    input  logic                           e_gr_we,
    input  logic                           e_mem_we,
    input  logic [31:0]                    e_rs,
    input  logic [31:0]                    e_rt,
    input  logic                           e_taken,
    input  logic [31:0]                    e_target,
    input  logic                           e_allowin,
    input  logic [9:0]                     e_src,
    input  logic                           e_is_branch,
    input  logic                           ds_to_es_valid,
    input  mips_id_pkg::ds_to_es_t         ds_to_es,
    input  mips_id_pkg::br_bus_t           br,
    input  logic                           ds_allowin,
    input  mips_id_pkg::src_addr_t         src_addrs,
    input  logic                           is_branch,
    output int                             done_id,
    output int                             err_count,
    output int                             pass_count
);

    // first wrong field decides the line for the test
    task automatic compare_outputs();
        if (ds_to_es_valid !== e_valid) begin
            $display("mismatch %0s valid expected %h actual %h", name, e_valid, ds_to_es_valid);
            err_count++;
        end else if (ds_allowin !== e_allowin) begin
            $display("mismatch %0s allowin expected %h actual %h", name, e_allowin, ds_allowin);
            err_count++;
        end else if (ds_to_es.ctrl.alu_op !== e_alu_op) begin
            $display("mismatch %0s alu_op expected %h actual %h",
                     name, e_alu_op, ds_to_es.ctrl.alu_op);
            err_count++;
        end else if (ds_to_es.ctrl.dest !== e_dest) begin
            $display("mismatch %0s dest expected %h actual %h", name, e_dest, ds_to_es.ctrl.dest);
            err_count++;
        end else if (ds_to_es.ctrl.gr_we !== e_gr_we) begin
            $display("mismatch %0s gr_we expected %h actual %h",
                     name, e_gr_we, ds_to_es.ctrl.gr_we);
            err_count++;
        end else if (ds_to_es.ctrl.mem_we !== e_mem_we) begin
            $display("mismatch %0s mem_we expected %h actual %h",
                     name, e_mem_we, ds_to_es.ctrl.mem_we);
            err_count++;
        end else if (ds_to_es.rs_value !== e_rs) begin
            $display("mismatch %0s rs_value expected %h actual %h", name, e_rs, ds_to_es.rs_value);
            err_count++;
        end else if (ds_to_es.rt_value !== e_rt) begin
            $display("mismatch %0s rt_value expected %h actual %h", name, e_rt, ds_to_es.rt_value);
            err_count++;
        end else if (src_addrs !== e_src) begin
            $display("mismatch %0s src_addrs expected %h actual %h", name, e_src, src_addrs);
            err_count++;
        end else if (is_branch !== e_is_branch) begin
            $display("mismatch %0s is_branch expected %h actual %h",
                     name, e_is_branch, is_branch);
            err_count++;
        end else if (br.taken !== e_taken) begin
            $display("mismatch %0s taken expected %h actual %h", name, e_taken, br.taken);
            err_count++;
        end else if (e_taken && br.target !== e_target) begin
            // target only matters for a redirect
            $display("mismatch %0s target expected %h actual %h", name, e_target, br.target);
            err_count++;
        end else begin
            $display("pass %0s", name);
            pass_count++;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            done_id    <= 0;
            err_count  = 0;
            pass_count = 0;
        end else if (req_id != done_id) begin
            compare_outputs();
            done_id <= req_id;
        end
    end

endmodule

/* tb_id_stage.sv */
`timescale 1ns/100ps

module tb_id_stage;

    logic                           clk;
    logic                           rst;
    logic                           fs_to_ds_valid;
    mips_id_pkg::fs_to_ds_t         fs_to_ds;
    logic                           ds_allowin;
    logic                           es_allowin;
    logic                           ds_to_es_valid;
    mips_id_pkg::ds_to_es_t         ds_to_es;
    mips_id_pkg::rf_write_t         ws_to_rf;
    logic [mips_id_pkg::word_w-1:0] fwd_data;
    mips_id_pkg::fwd_t              fwd;
    logic [1:0]                     stall;
    logic                           flush;
    mips_id_pkg::br_bus_t           br;
    mips_id_pkg::src_addr_t         src_addrs;
    logic                           is_branch;

    // one trace line, stimulus then expected values
    logic [127:0] t_name;
    logic [31:0]  t_pre_we, t_pre_addr, t_pre_data, t_pc, t_inst;
    logic [31:0]  t_fwd, t_fwd_data, t_stall, t_flush, t_es_allowin;
    logic [31:0]  e_valid, e_alu_op, e_dest, e_gr_we, e_mem_we;
    logic [31:0]  e_rs, e_rt, e_taken, e_target, e_allowin;
    logic [9:0]   e_src;
    logic         e_is_branch;

    int    req_id;
    int    done_id;
    int    err_count;
    int    pass_count;
    int    bad_lines;
    bit    timed_out;
    int    fd;
    int    code;
    int    n;
    string line;

    id_stage id_stage_inst (
        .clk            (clk),
        .rst            (rst),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds       (fs_to_ds),
        .ds_allowin     (ds_allowin),
        .es_allowin     (es_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es       (ds_to_es),
        .ws_to_rf       (ws_to_rf),
        .fwd_data       (fwd_data),
        .fwd            (fwd),
        .stall          (stall),
        .flush          (flush),
        .br             (br),
        .src_addrs      (src_addrs),
        .is_branch      (is_branch)
    );

    id_checker id_checker_inst (
        .clk            (clk),
        .rst            (rst),
        .req_id         (req_id),
        .name           (t_name),
        .e_valid        (e_valid[0]),
        .e_alu_op       (e_alu_op[11:0]),
        .e_dest         (e_dest[4:0]),
        .e_gr_we        (e_gr_we[0]),
        .e_mem_we       (e_mem_we[0]),
        .e_rs           (e_rs),
        .e_rt           (e_rt),
        .e_taken        (e_taken[0]),
        .e_target       (e_target),
        .e_allowin      (e_allowin[0]),
        .e_src          (e_src),
        .e_is_branch    (e_is_branch),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es       (ds_to_es),
        .br             (br),
        .ds_allowin     (ds_allowin),
        .src_addrs      (src_addrs),
        .is_branch      (is_branch),
        .done_id        (done_id),
        .err_count      (err_count),
        .pass_count     (pass_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic idle_controls();
        fs_to_ds_valid = 1'b0;
        es_allowin     = 1'b1;
        stall          = mips_id_pkg::stall_run;
        flush          = 1'b0;
        fwd            = '0;
        fwd_data       = '0;
    endtask

    // beq, bne, blez and bgtz with rt zero, regimm bltz and bgez
    function automatic logic cond_branch_word(logic [31:0] word);
        logic [5:0] op;
        logic [4:0] rt;
        op = word[31:26];
        rt = word[20:16];
        case (op)
            6'h04, 6'h05: return 1'b1;
            6'h06, 6'h07: return rt == 5'd0;
            6'h01:        return rt == 5'd0 || rt == 5'd1;
            default:      return 1'b0;
        endcase
    endfunction

    // preload, accept at one edge, apply the test controls, then ask for a check
    task automatic run_test();
        int cycles;
        if (t_pre_we[0]) begin
            @(negedge clk);
            ws_to_rf = {1'b1, t_pre_addr[4:0], t_pre_data};
            @(negedge clk);
            ws_to_rf = '0;
        end
        @(negedge clk);
        idle_controls();
        fs_to_ds_valid = 1'b1;
        fs_to_ds       = {t_inst, t_pc};
        @(negedge clk);
        fs_to_ds_valid = 1'b0;
        fwd            = t_fwd[1:0];
        fwd_data       = t_fwd_data;
        stall          = t_stall[1:0];
        es_allowin     = t_es_allowin[0];
        flush          = t_flush[0];
        if (t_flush[0]) begin
            @(negedge clk);
            flush = 1'b0;
        end
        // rs and rt fields of the word
        e_src       = {t_inst[25:21], t_inst[20:16]};
        e_is_branch = cond_branch_word(t_inst);
        req_id = req_id + 1;
        cycles = 0;
        while (done_id != req_id && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (done_id != req_id) begin
            $display("checker gave no result for test %0s", t_name);
            timed_out = 1'b1;
        end
        idle_controls();
    endtask

    initial begin
        rst       = 1'b1;
        fs_to_ds  = '0;
        ws_to_rf  = '0;
        req_id    = 0;
        bad_lines = 0;
        timed_out = 1'b0;
        idle_controls();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        fd = $fopen("id_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file id_trace.txt");
            bad_lines++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line,
                        "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        t_name, t_pre_we, t_pre_addr, t_pre_data, t_pc, t_inst, t_fwd,
                        t_fwd_data, t_stall, t_flush, t_es_allowin, e_valid, e_alu_op,
                        e_dest, e_gr_we, e_mem_we, e_rs, e_rt, e_taken, e_target,
                        e_allowin);
                    if (n == 21) begin
                        run_test();
                    end else begin
                        $display("trace line could not be read: %s", line);
                        bad_lines++;
                    end
                end
            end
            $fclose(fd);
        end
        $display("tests passed %0d, failed %0d, unreadable lines %0d",
                 pass_count, err_count, bad_lines);
        if (err_count == 0 && bad_lines == 0 && !timed_out && pass_count > 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* id_trace.txt */
# name pre_we pre_addr pre_data pc inst fwd fwd_data stall flush es_allowin
# exp: valid alu_op dest gr_we mem_we rs_value rt_value taken target allowin
wr_r8_addu 1 08 00000005 00400000 01095021 0 00000000 0 0 1 1 001 0a 1 0 00000005 00000000 0 00000000 1
wr_r9_subu 1 09 fffffff0 00400000 01095823 0 00000000 0 0 1 1 002 0b 1 0 00000005 fffffff0 0 00000000 1
slt 0 00 00000000 00400000 0128602a 0 00000000 0 0 1 1 004 0c 1 0 fffffff0 00000005 0 00000000 1
sll 0 00 00000000 00400000 00081100 0 00000000 0 0 1 1 100 02 1 0 00000000 00000005 0 00000000 1
srav 0 00 00000000 00400000 01281807 0 00000000 0 0 1 1 400 03 1 0 fffffff0 00000005 0 00000000 1
nor 0 00 00000000 00400000 01092027 0 00000000 0 0 1 1 020 04 1 0 00000005 fffffff0 0 00000000 1
addiu 0 00 00000000 00400000 2505ffff 0 00000000 0 0 1 1 001 05 1 0 00000005 00000000 0 00000000 1
andi 0 00 00000000 00400000 312600ff 0 00000000 0 0 1 1 010 06 1 0 fffffff0 00000000 0 00000000 1
sltiu 0 00 00000000 00400000 2d070005 0 00000000 0 0 1 1 008 07 1 0 00000005 00000000 0 00000000 1
lui 0 00 00000000 00400000 3c0d1234 0 00000000 0 0 1 1 800 0d 1 0 00000000 00000000 0 00000000 1
lw 0 00 00000000 00400000 8d0e0008 0 00000000 0 0 1 1 001 0e 1 0 00000005 00000000 0 00000000 1
sw 0 00 00000000 00400000 ad090004 0 00000000 0 0 1 1 001 00 0 1 00000005 fffffff0 0 00000000 1
unknown 0 00 00000000 00400000 fc000000 0 00000000 0 0 1 1 000 00 0 0 00000000 00000000 0 00000000 1
r0_write 1 00 deadbeef 00400000 00000821 0 00000000 0 0 1 1 001 01 1 0 00000000 00000000 0 00000000 1
fwd_both 0 00 00000000 00400000 01095021 3 a5a5a5a5 0 0 1 1 001 0a 1 0 a5a5a5a5 a5a5a5a5 0 00000000 1
fwd_rt 0 00 00000000 00400000 01095021 1 11111111 0 0 1 1 001 0a 1 0 00000005 11111111 0 00000000 1
beq_taken 0 00 00000000 00400000 11080004 0 00000000 0 0 1 1 000 00 0 0 00000005 00000005 1 00400014 1
beq_not 0 00 00000000 00400000 11090004 0 00000000 0 0 1 1 000 00 0 0 00000005 fffffff0 0 00000000 1
bne_taken 0 00 00000000 00400000 1509fffe 0 00000000 0 0 1 1 000 1f 0 0 00000005 fffffff0 1 003ffffc 1
bne_not 0 00 00000000 00400000 15080010 0 00000000 0 0 1 1 000 00 0 0 00000005 00000005 0 00000000 1
bgez_taken 0 00 00000000 00400000 05010001 0 00000000 0 0 1 1 000 00 0 0 00000005 00000000 1 00400008 1
bgez_not 0 00 00000000 00400000 05210001 0 00000000 0 0 1 1 000 00 0 0 fffffff0 00000000 0 00000000 1
bltz_taken 0 00 00000000 00400000 05200002 0 00000000 0 0 1 1 000 00 0 0 fffffff0 00000000 1 0040000c 1
bltz_not 0 00 00000000 00400000 05000002 0 00000000 0 0 1 1 000 00 0 0 00000005 00000000 0 00000000 1
bgtz_taken 0 00 00000000 00400000 1d000003 0 00000000 0 0 1 1 000 00 0 0 00000005 00000000 1 00400010 1
bgtz_not 0 00 00000000 00400000 1c000003 0 00000000 0 0 1 1 000 00 0 0 00000000 00000000 0 00000000 1
blez_taken 0 00 00000000 00400000 18000005 0 00000000 0 0 1 1 000 00 0 0 00000000 00000000 1 00400018 1
blez_not 0 00 00000000 00400000 19000005 0 00000000 0 0 1 1 000 00 0 0 00000005 00000000 0 00000000 1
j 0 00 00000000 00400000 08000100 0 00000000 0 0 1 1 000 00 0 0 00000000 00000000 1 00000400 1
jal 0 00 00000000 00400000 0c040000 0 00000000 0 0 1 1 001 1f 1 0 00000000 00000000 1 00100000 1
jr 0 00 00000000 00400000 01000008 0 00000000 0 0 1 1 000 00 0 0 00000005 00000000 1 00000005 1
jalr 0 00 00000000 00400000 0120f809 0 00000000 0 0 1 1 001 1f 1 0 fffffff0 00000000 1 fffffff0 1
stall_hold 0 00 00000000 00400000 01095021 0 00000000 1 0 1 0 001 0a 1 0 00000005 fffffff0 0 00000000 0
stall_bubble 0 00 00000000 00400000 01095021 0 00000000 2 0 1 0 001 0a 1 0 00000005 fffffff0 0 00000000 1
flush_branch 0 00 00000000 00400000 11080004 0 00000000 0 1 1 0 000 00 0 0 00000005 00000005 0 00000000 1
backpressure 0 00 00000000 00400000 01095021 0 00000000 0 0 0 1 001 0a 1 0 00000005 fffffff0 0 00000000 0

/* id_stage.f */
mips_id_pkg.sv
id_pipe_ctrl.sv
inst_decoder.sv
reg_file.sv
operand_fwd.sv
branch_unit.sv
id_stage.sv
id_checker.sv
tb_id_stage.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= id_stage.f
TB_TOP    ?= tb_id_stage
RTL_TOP   ?= id_stage
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
